// ==== cachePkg.sv ====
`default_nettype none

package cachePkg;

  // core word and fetch address
  localparam int XLEN = 64;
  localparam int ADDR_W = 32;

  // 32-byte lines, 64 sets of 2 ways
  localparam int OFFSET_W = 5;
  localparam int INDEX_W = 6;
  localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
  localparam int SETS = 1 << INDEX_W;
  localparam int WAYS = 2;
  localparam int LINE_BEATS = 4;

  typedef logic [ADDR_W-1:0] addrT;
  typedef logic [XLEN-1:0] wordT;

  // word 0 sits in the low bits
  typedef logic [LINE_BEATS*XLEN-1:0] lineT;

  typedef logic [TAG_W-1:0] tagT;
  typedef logic [INDEX_W-1:0] indexT;
  typedef logic [$clog2(LINE_BEATS)-1:0] beatT;

  // request controller
  typedef enum logic [1:0] {
    idle,
    compare,
    miss,
    refill
  } cacheStateT;

endpackage

`default_nettype wire

// ==== cacheSram.sv ====
`timescale 1ns/10ps
`default_nettype none

module cacheSram
  import cachePkg::*;
(
  input  wire        clk,
  input  wire        cen_i,
  input  wire        wen_i,
  input  wire indexT addr_i,
  input  wire lineT  wdata_i,
  output lineT       rdata_o
);

  // one full line per set
  lineT mem [SETS];

  // single port, a write cycle leaves the read data as it was
  always_ff @(posedge clk) begin
    if (cen_i) begin
      if (wen_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== cacheTagArray.sv ====
`timescale 1ns/10ps
`default_nettype none

module cacheTagArray
  import cachePkg::*;
(
  input  wire        clk,
  input  wire        rst_n,
  input  wire        rdEn_i,
  input  wire indexT rdIndex_i,
  input  wire tagT   cmpTag_i,
  output logic       hit_o,
  output logic       hitWay_o,
  input  wire        fillEn_i,
  input  wire indexT fillIndex_i,
  input  wire tagT   fillTag_i,
  output logic       victimWay_o,
  input  wire        touchEn_i
);

  tagT tagMem [WAYS][SETS];
  logic [SETS-1:0] validMem [WAYS];
  // per set, the way to replace next
  logic [SETS-1:0] lruMem;

  // state of the set under lookup
  tagT tagQ [WAYS];
  logic [WAYS-1:0] validQ;
  logic lruQ;
  indexT lookupIndexQ;
  logic [WAYS-1:0] wayHit;

  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      tagMem[victimWay_o][fillIndex_i] <= fillTag_i;
    end
    if (rdEn_i) begin
      for (int w = 0; w < WAYS; w++) begin
        tagQ[w] <= tagMem[w][rdIndex_i];
      end
      lookupIndexQ <= rdIndex_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < WAYS; w++) begin
        validMem[w] <= '0;
      end
      lruMem <= '0;
      validQ <= '0;
      lruQ <= 1'b0;
    end else begin
      // filled or hit way becomes most recent
      if (fillEn_i) begin
        validMem[victimWay_o][fillIndex_i] <= 1'b1;
        lruMem[fillIndex_i] <= ~victimWay_o;
      end else if (touchEn_i) begin
        lruMem[lookupIndexQ] <= ~hitWay_o;
      end
      if (rdEn_i) begin
        for (int w = 0; w < WAYS; w++) begin
          validQ[w] <= validMem[w][rdIndex_i];
        end
        // a hit retiring on this edge to the same set has just moved its lru bit
        if (touchEn_i && (rdIndex_i == lookupIndexQ)) begin
          lruQ <= ~hitWay_o;
        end else begin
          lruQ <= lruMem[rdIndex_i];
        end
      end
    end
  end

  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      wayHit[w] = validQ[w] && (tagQ[w] == cmpTag_i);
    end
  end

  assign hit_o = |wayHit;
  assign hitWay_o = wayHit[1];
  assign victimWay_o = lruQ;

endmodule

`default_nettype wire

// ==== cacheRefill.sv ====
`timescale 1ns/10ps
`default_nettype none

module cacheRefill
  import cachePkg::*;
(
  input  wire       clk,
  input  wire       rst_n,
  input  wire       refillReq_i,
  input  wire addrT refillAddr_i,
  output logic      refillDone_o,
  output lineT      refillLine_o,
  output logic      cacheRdValid_o,
  output addrT      cacheAddr_o,
  input  wire       rdReady_i,
  input  wire       rdDataValid_i,
  input  wire wordT rdData_i,
  input  wire       rdLast_i
);

  typedef enum logic [1:0] {
    refIdle,
    refAddr,
    refBeat
  } refillStateT;

  refillStateT stateQ;
  beatT beatQ;
  logic [ADDR_W-OFFSET_W-1:0] lineAddrQ;
  logic startReq;
  logic lastBeat;

  // request is still high during the done pulse, so don't restart on it
  assign startReq = refillReq_i && !refillDone_o;
  assign lastBeat = (stateQ == refBeat) && rdDataValid_i && rdLast_i;

  assign cacheRdValid_o = (stateQ == refAddr);
  assign cacheAddr_o = {lineAddrQ, {OFFSET_W{1'b0}}};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ <= refIdle;
      beatQ <= '0;
      refillDone_o <= 1'b0;
    end else begin
      refillDone_o <= lastBeat;
      case (stateQ)
        refIdle: begin
          if (startReq) begin
            stateQ <= refAddr;
          end
        end
        refAddr: begin
          // address handshake
          if (rdReady_i) begin
            stateQ <= refBeat;
            beatQ <= '0;
          end
        end
        refBeat: begin
          if (rdDataValid_i) begin
            beatQ <= beatQ + 1'b1;
            if (rdLast_i) begin
              stateQ <= refIdle;
            end
          end
        end
        default: begin
          stateQ <= refIdle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((stateQ == refIdle) && startReq) begin
      lineAddrQ <= refillAddr_i[ADDR_W-1:OFFSET_W];
    end
    // beats arrive in order, beat 0 first
    if ((stateQ == refBeat) && rdDataValid_i) begin
      refillLine_o[beatQ*XLEN +: XLEN] <= rdData_i;
    end
  end

endmodule

`default_nettype wire

// ==== cache.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache
  import cachePkg::*;
(
  input  wire       clk,
  input  wire       rst_n,
  input  wire       valid_i,
  input  wire addrT addr_i,
  output logic      addr_ok_o,
  output logic      data_ok_o,
  output wordT      rdData_o,
  output logic      refillReq_o,
  output addrT      refillAddr_o,
  input  wire       refillDone_i,
  input  wire lineT refillLine_i
);

  cacheStateT stateQ;
  cacheStateT stateNext;

  // latched request
  addrT reqAddrQ;
  tagT reqTag;
  indexT reqIndex;
  beatT reqBeat;

  indexT lookupIndex;
  indexT sramIndex;
  logic accept;
  logic hit;
  logic hitWay;
  logic victimWay;
  logic lookupHit;
  logic fillEn;
  logic sramCen;
  lineT wayLine [WAYS];
  lineT hitLine;
  lineT outLine;

  assign reqTag = reqAddrQ[ADDR_W-1 -: TAG_W];
  assign reqIndex = reqAddrQ[OFFSET_W +: INDEX_W];
  assign reqBeat = reqAddrQ[OFFSET_W-1 -: $clog2(LINE_BEATS)];
  assign lookupIndex = addr_i[OFFSET_W +: INDEX_W];

  assign lookupHit = (stateQ == compare) && hit;
  assign fillEn = (stateQ == refill) && refillDone_i;

  // a hit in compare frees the pipe for the next request
  assign addr_ok_o = (stateQ == idle) || lookupHit;
  assign accept = valid_i && addr_ok_o;

  assign refillReq_o = (stateQ == miss) || (stateQ == refill);
  assign refillAddr_o = {reqTag, reqIndex, {OFFSET_W{1'b0}}};

  always_comb begin
    stateNext = stateQ;
    case (stateQ)
      idle: begin
        if (valid_i) begin
          stateNext = compare;
        end
      end
      compare: begin
        if (!hit) begin
          stateNext = miss;
        end else if (!valid_i) begin
          stateNext = idle;
        end
      end
      miss: begin
        stateNext = refill;
      end
      refill: begin
        if (refillDone_i) begin
          stateNext = idle;
        end
      end
      default: begin
        stateNext = idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ <= idle;
      data_ok_o <= 1'b0;
    end else begin
      stateQ <= stateNext;
      data_ok_o <= lookupHit || fillEn;
    end
  end

  // miss returns its word straight from the refill line
  assign hitLine = wayLine[hitWay];
  assign outLine = fillEn ? refillLine_i : hitLine;

  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddrQ <= addr_i;
    end
    if (lookupHit || fillEn) begin
      rdData_o <= outLine[reqBeat*XLEN +: XLEN];
    end
  end

  // lookup and fill never share a cycle
  assign sramCen = accept || fillEn;
  assign sramIndex = fillEn ? reqIndex : lookupIndex;

  for (genvar w = 0; w < WAYS; w++) begin : gWay
    cacheSram uSram (
      .clk     (clk),
      .cen_i   (sramCen),
      .wen_i   (fillEn && (victimWay == w)),
      .addr_i  (sramIndex),
      .wdata_i (refillLine_i),
      .rdata_o (wayLine[w])
    );
  end

  cacheTagArray uTags (
    .clk         (clk),
    .rst_n       (rst_n),
    .rdEn_i      (accept),
    .rdIndex_i   (lookupIndex),
    .cmpTag_i    (reqTag),
    .hit_o       (hit),
    .hitWay_o    (hitWay),
    .fillEn_i    (fillEn),
    .fillIndex_i (reqIndex),
    .fillTag_i   (reqTag),
    .victimWay_o (victimWay),
    .touchEn_i   (lookupHit)
  );

endmodule

`default_nettype wire

// ==== cacheTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module cacheTop
  import cachePkg::*;
(
  input  wire       clk,
  input  wire       rst_n,
  // fetch side
  input  wire       valid_i,
  input  wire addrT addr_i,
  output wire       addr_ok_o,
  output wire       data_ok_o,
  output wordT      rdData_o,
  // burst read bus
  output wire       cacheRdValid_o,
  output addrT      cacheAddr_o,
  input  wire       rdReady_i,
  input  wire       rdDataValid_i,
  input  wire wordT rdData_i,
  input  wire       rdLast_i
);

  wire refillReq;
  wire refillDone;
  addrT refillAddr;
  lineT refillLine;

  cache uCache (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_i      (valid_i),
    .addr_i       (addr_i),
    .addr_ok_o    (addr_ok_o),
    .data_ok_o    (data_ok_o),
    .rdData_o     (rdData_o),
    .refillReq_o  (refillReq),
    .refillAddr_o (refillAddr),
    .refillDone_i (refillDone),
    .refillLine_i (refillLine)
  );

  cacheRefill uRefill (
    .clk            (clk),
    .rst_n          (rst_n),
    .refillReq_i    (refillReq),
    .refillAddr_i   (refillAddr),
    .refillDone_o   (refillDone),
    .refillLine_o   (refillLine),
    .cacheRdValid_o (cacheRdValid_o),
    .cacheAddr_o    (cacheAddr_o),
    .rdReady_i      (rdReady_i),
    .rdDataValid_i  (rdDataValid_i),
    .rdData_i       (rdData_i),
    .rdLast_i       (rdLast_i)
  );

endmodule

`default_nettype wire

// ==== cacheTop_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module cacheTop_chk
  import cachePkg::*;
(
  input wire       clk,
  input wire       rst_n,
  input wire       valid_i,
  input wire       addrOk_i,
  input wire       dataOk_i,
  input wire       rdValid_i,
  input wire addrT busAddr_i,
  input wire       rdReady_i,
  input wire addrT lineReq_i
);

  // accepted requests still waiting for data
  int pending;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= 0;
    end else begin
      pending <= pending + int'(valid_i && addrOk_i) - int'(dataOk_i);
    end
  end

  addrHold: assert property (@(posedge clk) disable iff (!rst_n)
    rdValid_i && !rdReady_i |=> rdValid_i && $stable(busAddr_i))
    else $error("bus request dropped or changed before the handshake");

  // bus address is the aligned line of the miss in progress
  lineAligned: assert property (@(posedge clk) disable iff (!rst_n)
    rdValid_i |-> busAddr_i == {lineReq_i[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}})
    else $error("bus address is not the aligned line of the pending miss");

  noOrphanData: assert property (@(posedge clk) disable iff (!rst_n)
    dataOk_i |-> pending != 0)
    else $error("data_ok_o without an outstanding request");

  quietInReset: assert property (@(posedge clk)
    !rst_n |-> !dataOk_i && !rdValid_i)
    else $error("outputs active during reset");

endmodule

bind cacheTop cacheTop_chk uChk (
  .clk       (clk),
  .rst_n     (rst_n),
  .valid_i   (valid_i),
  .addrOk_i  (addr_ok_o),
  .dataOk_i  (data_ok_o),
  .rdValid_i (cacheRdValid_o),
  .busAddr_i (cacheAddr_o),
  .rdReady_i (rdReady_i),
  .lineReq_i (refillAddr)
);

`default_nettype wire

// ==== tbCache.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbCache
  import cachePkg::*;
();

  logic clk;
  logic rst_n;
  logic valid;
  addrT addr;
  wire  addrOk;
  wire  dataOk;
  wordT rdData;
  wire  rdValid;
  addrT busAddr;
  logic rdReady;
  logic rdDataValid;
  wordT rdDataBus;
  logic rdLast;

  integer seed;
  int missCount;
  int refillCount;

  // backing memory of 8-byte words
  wordT memWords [4096];

  // reference cache state
  tagT  modelTag [SETS][WAYS];
  logic modelValid [SETS][WAYS];
  logic modelLru [SETS];

  // in-order expectations
  wordT expWord [$];
  time  expTime [$];
  logic expHit [$];
  addrT expLine [$];

  cacheTop dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (valid),
    .addr_i         (addr),
    .addr_ok_o      (addrOk),
    .data_ok_o      (dataOk),
    .rdData_o       (rdData),
    .cacheRdValid_o (rdValid),
    .cacheAddr_o    (busAddr),
    .rdReady_i      (rdReady),
    .rdDataValid_i  (rdDataValid),
    .rdData_i       (rdDataBus),
    .rdLast_i       (rdLast)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic reportFail(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  function automatic wordT memRead(input addrT a);
    return memWords[a[14:3]];
  endfunction

  function automatic addrT makeAddr(input int tag, input int idx, input int word);
    return {tag[TAG_W-1:0], idx[INDEX_W-1:0], word[1:0], 3'b000};
  endfunction

  // the accessed way becomes most recent and a miss fills the lru way
  function automatic logic modelAccess(input addrT a);
    tagT t;
    indexT i;
    logic way;
    t = a[ADDR_W-1 -: TAG_W];
    i = a[OFFSET_W +: INDEX_W];
    for (int w = 0; w < WAYS; w++) begin
      if (modelValid[i][w] && modelTag[i][w] == t) begin
        modelLru[i] = (w == 0);
        return 1'b1;
      end
    end
    way = modelLru[i];
    modelTag[i][way] = t;
    modelValid[i][way] = 1'b1;
    modelLru[i] = ~way;
    return 1'b0;
  endfunction

  task automatic sendReq(input addrT a, output int waited, output logic hit);
    int n;
    n = 0;
    valid = 1'b1;
    addr = a;
    @(negedge clk);
    while (!addrOk) begin
      n++;
      assert (n < 200) else reportFail("request was never accepted");
      @(negedge clk);
    end
    @(posedge clk);
    hit = modelAccess(a);
    expWord.push_back(memRead(a));
    expTime.push_back($time);
    expHit.push_back(hit);
    if (!hit) begin
      missCount++;
      expLine.push_back({a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}});
    end
    #1;
    valid = 1'b0;
    waited = n;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (expWord.size() != 0) begin
      n++;
      assert (n < 500) else reportFail("responses did not drain");
      @(posedge clk);
      #1;
    end
  endtask

  // response monitor samples outputs at the falling edge
  always @(negedge clk) begin
    wordT w;
    time t;
    logic h;
    if (rst_n && dataOk) begin
      assert (expWord.size() > 0) else reportFail("data_ok_o without a pending request");
      w = expWord.pop_front();
      t = expTime.pop_front();
      h = expHit.pop_front();
      assert (rdData == w)
        else reportFail($sformatf("ERR rdData_o got %h expected %h", rdData, w));
      // the rising edge that samples data_ok_o is 10 ns after this falling edge
      if (h) begin
        assert ($time + 10 - t == 40)
          else reportFail($sformatf("ERR data_ok_o hit latency %h ns expected %h ns",
                                    $time + 10 - t, 40));
      end
    end
  end

  task automatic serveLine();
    addrT la;
    addrT exp;
    int d;
    int gap;
    la = busAddr;
    assert (expLine.size() > 0) else reportFail("unexpected line request on the bus");
    exp = expLine.pop_front();
    assert (la == exp)
      else reportFail($sformatf("ERR cacheAddr_o got %h expected %h", la, exp));
    refillCount++;
    d = {$random(seed)} % 4;
    @(posedge clk);
    repeat (d) @(posedge clk);
    #1;
    rdReady = 1'b1;
    @(posedge clk);
    #1;
    rdReady = 1'b0;
    for (int b = 0; b < LINE_BEATS; b++) begin
      gap = {$random(seed)} % 3;
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      rdDataValid = 1'b1;
      rdDataBus = memRead(la + b * 8);
      rdLast = (b == LINE_BEATS - 1);
      @(posedge clk);
      #1;
      rdDataValid = 1'b0;
      rdLast = 1'b0;
    end
  endtask

  // bus memory model
  initial begin
    forever begin
      @(negedge clk);
      if (rst_n && rdValid) begin
        serveLine();
      end
    end
  end

  initial begin
    int waited;
    logic hit;
    logic expPattern [6];
    int tagsA [6];
    int idxPool [4];
    int g;
    seed = 61;
    valid = 1'b0;
    addr = '0;
    rdReady = 1'b0;
    rdDataValid = 1'b0;
    rdDataBus = '0;
    rdLast = 1'b0;
    rst_n = 1'b0;
    missCount = 0;
    refillCount = 0;
    for (int i = 0; i < 4096; i++) begin
      memWords[i] = {$random(seed), $random(seed)};
    end
    for (int s = 0; s < SETS; s++) begin
      modelLru[s] = 1'b0;
      for (int w = 0; w < WAYS; w++) begin
        modelValid[s][w] = 1'b0;
        modelTag[s][w] = '0;
      end
    end
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // lru eviction in set 9 with tags A B A C A B
    tagsA = '{10, 11, 10, 12, 10, 11};
    expPattern = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
    for (int k = 0; k < 6; k++) begin
      sendReq(makeAddr(tagsA[k], 9, k % 4), waited, hit);
      assert (hit == expPattern[k]) else reportFail("reference model broke the lru order");
    end
    drain();

    // tag 10 stays resident so every request goes straight through
    for (int k = 0; k < 8; k++) begin
      sendReq(makeAddr(10, 9, {$random(seed)} % 4), waited, hit);
      assert (waited == 0) else reportFail("hit stream was stalled");
    end
    drain();

    // random traffic over a small pool of lines
    idxPool = '{0, 5, 12, 33};
    for (int k = 0; k < 300; k++) begin
      sendReq(makeAddr({$random(seed)} % 4, idxPool[{$random(seed)} % 4],
                       {$random(seed)} % 4), waited, hit);
      if ({$random(seed)} % 4 == 0) begin
        g = 1 + {$random(seed)} % 2;
        repeat (g) begin
          @(posedge clk);
          #1;
        end
      end
    end
    drain();
    repeat (5) @(posedge clk);

    assert (refillCount == missCount)
      else reportFail($sformatf("ERR refill count got %h expected %h", refillCount, missCount));
    assert (expLine.size() == 0) else reportFail("some expected line requests never came");
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
cachePkg.sv
cacheSram.sv
cacheTagArray.sv
cacheRefill.sv
cache.sv
cacheTop.sv
cacheTop_chk.sv
tbCache.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tbCache
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "Regression passed" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
